// ==== dv/csr_data_checker.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_data_checker
    import csr_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input csr_read_req_t        read_req,
    input logic                 read_fault,
    input csr_write_req_t       write_req,
    input logic                 write_fault,
    input logic [`FRM_BITS-1:0] fpu_frm
);

    // A fault needs a request behind it
    a_read_fault_en: assert property (
        @(posedge clk) disable iff (reset) read_fault |-> read_req.enable
    ) else $error("read_fault raised without a read enable");

    a_write_fault_en: assert property (
        @(posedge clk) disable iff (reset) write_fault |-> write_req.enable
    ) else $error("write_fault raised without a write enable");

    // Rounding mode fully driven once out of reset
    a_frm_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(fpu_frm)
    ) else $error("fpu_frm has unknown bits");

endmodule

// ==== dv/csr_data_tb.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_data_tb
    import csr_pkg::*;
();

    localparam int CORE_ID = 1;
    localparam int TIMEOUT = 50;

    localparam csr_addr_t MACH_ADDR [9] = '{
        `CSR_SATP, `CSR_MSTATUS, `CSR_MEDELEG, `CSR_MIDELEG, `CSR_MIE,
        `CSR_MTVEC, `CSR_MEPC, `CSR_PMPCFG0, `CSR_PMPADDR0
    };
    localparam csr_addr_t FP_ADDR [3] = '{`CSR_FFLAGS, `CSR_FRM, `CSR_FCSR};
    localparam csr_addr_t ID_ADDR [14] = '{
        `CSR_WTID, `CSR_LTID, `CSR_GTID, `CSR_LWID, `CSR_GWID, `CSR_GCID, `CSR_TMASK,
        `CSR_NT, `CSR_NW, `CSR_NC, `CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID
    };
    localparam csr_addr_t CTR_ADDR [4] = '{
        `CSR_MCYCLE, `CSR_MCYCLE_H, `CSR_MINSTRET, `CSR_MINSTRET_H
    };
    localparam csr_addr_t BAD_ADDR [5] = '{12'h000, 12'h004, 12'h7FF, 12'hCC7, 12'hFC3};
    localparam csr_addr_t RO_ADDR [8] = '{
        `CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID,
        `CSR_MCYCLE, `CSR_MINSTRET_H, `CSR_WTID, `CSR_NC
    };

    logic                 clk;
    logic                 reset;
    csr_read_req_t        read_req;
    thread_data_t         read_data;
    logic                 read_fault;
    csr_write_req_t       write_req;
    logic                 write_fault;
    fpu_flags_req_t       fpu_flags;
    warp_id_t             fpu_read_wid;
    logic [`FRM_BITS-1:0] fpu_frm;
    perf_ctr_t            cycles;
    perf_ctr_t            instret;

    // Model of the DUT state
    fcsr_t       fcsr_m [`NUM_WARPS];
    logic [31:0] mreg_m [9];

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycles_seen;

    always #2 clk = ~clk;

    csr_data #(
        .core_id (CORE_ID)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .read_req     (read_req),
        .read_data    (read_data),
        .read_fault   (read_fault),
        .write_req    (write_req),
        .write_fault  (write_fault),
        .fpu_flags    (fpu_flags),
        .fpu_read_wid (fpu_read_wid),
        .fpu_frm      (fpu_frm),
        .cycles       (cycles),
        .instret      (instret)
    );

    bind csr_data csr_data_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .read_req    (read_req),
        .read_fault  (read_fault),
        .write_req   (write_req),
        .write_fault (write_fault),
        .fpu_frm     (fpu_frm)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic int pick(input int n);
        return int'(rand32() % 32'(n));
    endfunction

    function automatic tmask_t rand_mask();
        tmask_t m;
        m = tmask_t'(rand32());
        if (m == '0) begin
            m[0] = 1'b1;
        end
        return m;
    endfunction

    function automatic logic [`FFLAGS_BITS-1:0] rand_flags();
        logic [31:0] r;
        r = rand32();
        return r[`FFLAGS_BITS-1:0];
    endfunction

    function automatic int mreg_index(input csr_addr_t addr);
        for (int i = 0; i < 9; i++) begin
            if (addr == MACH_ADDR[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic writable(input csr_addr_t addr);
        return addr == `CSR_FFLAGS || addr == `CSR_FRM || addr == `CSR_FCSR
            || mreg_index(addr) >= 0;
    endfunction

    // Lowest active lane supplies the write value
    function automatic logic [31:0] lowest_lane(input csr_write_req_t w);
        for (int t = 0; t < `NUM_THREADS; t++) begin
            if (w.tmask[t]) begin
                return w.data[t];
            end
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] lane_ref(input csr_read_req_t r, input int t,
                                             output logic known);
        logic [31:0] gwid;
        fcsr_t       f;
        gwid  = CORE_ID * `NUM_WARPS + 32'(r.wid);
        f     = fcsr_m[r.wid];
        known = 1'b1;
        if (mreg_index(r.addr) >= 0) begin
            return mreg_m[mreg_index(r.addr)];
        end
        case (r.addr)
            `CSR_FFLAGS:     return 32'(f.fflags);
            `CSR_FRM:        return 32'(f.frm);
            `CSR_FCSR:       return 32'({f.frm, f.fflags});
            `CSR_WTID:       return 32'(t);
            `CSR_LTID:       return 32'(r.wid) * `NUM_THREADS + 32'(t);
            `CSR_GTID:       return gwid * `NUM_THREADS + 32'(t);
            `CSR_LWID:       return 32'(r.wid);
            `CSR_GWID:       return gwid;
            `CSR_GCID:       return 32'(CORE_ID);
            `CSR_TMASK:      return 32'(r.tmask);
            `CSR_NT:         return 32'(`NUM_THREADS);
            `CSR_NW:         return 32'(`NUM_WARPS);
            `CSR_NC:         return 32'(`NUM_CORES);
            `CSR_MISA:       return (32'd1 << 30) | `MISA_STD;
            `CSR_MVENDORID:  return `VENDOR_ID;
            `CSR_MARCHID:    return `ARCH_ID;
            `CSR_MIMPID:     return `IMPL_ID;
            `CSR_MCYCLE:     return cycles[31:0];
            `CSR_MCYCLE_H:   return 32'(cycles[`PERF_CTR_BITS-1:32]);
            `CSR_MINSTRET:   return instret[31:0];
            `CSR_MINSTRET_H: return 32'(instret[`PERF_CTR_BITS-1:32]);
            default: begin
                known = 1'b0;
                return 32'h0;
            end
        endcase
    endfunction

    function automatic thread_data_t read_ref(input csr_read_req_t r, output logic known);
        thread_data_t d;
        for (int t = 0; t < `NUM_THREADS; t++) begin
            d[t] = lane_ref(r, t, known);
        end
        return d;
    endfunction

    function void model_reset();
        for (int w = 0; w < `NUM_WARPS; w++) begin
            fcsr_m[w] = '0;
        end
        for (int i = 0; i < 9; i++) begin
            mreg_m[i] = 32'h0;
        end
    endfunction

    // FPU flags first, so a CSR write on the same warp overrides them
    function void model_update();
        logic [31:0] value;
        int          idx;
        if (fpu_flags.enable) begin
            fcsr_m[fpu_flags.wid].fflags |= fpu_flags.fflags;
        end
        if (write_req.enable && write_req.tmask != '0) begin
            value = lowest_lane(write_req);
            idx   = mreg_index(write_req.addr);
            case (write_req.addr)
                `CSR_FFLAGS: fcsr_m[write_req.wid].fflags = value[`FFLAGS_BITS-1:0];
                `CSR_FRM:    fcsr_m[write_req.wid].frm    = value[`FRM_BITS-1:0];
                `CSR_FCSR:   fcsr_m[write_req.wid] = fcsr_t'(value[7:0]);
                default: begin
                    if (idx >= 0) begin
                        mreg_m[idx] = value;
                    end
                end
            endcase
        end
    endfunction

    task automatic check_data(input string name, input thread_data_t got,
                              input thread_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_frm(input string name, input logic [`FRM_BITS-1:0] got,
                             input logic [`FRM_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Outputs are compared before the edge updates the model
    always @(posedge clk) begin
        thread_data_t exp_data;
        logic         known;
        if (reset) begin
            model_reset();
        end else begin
            cycles_seen++;
            exp_data = read_ref(read_req, known);
            if (read_req.enable) begin
                check_data("read_data", read_data, exp_data);
            end
            check_bit("read_fault", read_fault, read_req.enable && !known);
            check_bit("write_fault", write_fault,
                      write_req.enable && !writable(write_req.addr));
            check_frm("fpu_frm", fpu_frm, fcsr_m[fpu_read_wid].frm);
            model_update();
        end
    end

    function automatic csr_read_req_t rd_req(input warp_id_t wid, input tmask_t mask,
                                             input csr_addr_t addr);
        csr_read_req_t r;
        r.enable = 1'b1;
        r.wid    = wid;
        r.tmask  = mask;
        r.addr   = addr;
        return r;
    endfunction

    function automatic csr_write_req_t wr_req(input warp_id_t wid, input tmask_t mask,
                                              input csr_addr_t addr);
        csr_write_req_t w;
        w.enable = 1'b1;
        w.wid    = wid;
        w.tmask  = mask;
        w.addr   = addr;
        for (int t = 0; t < `NUM_THREADS; t++) begin
            w.data[t] = rand32();
        end
        return w;
    endfunction

    function automatic fpu_flags_req_t fpu_req(input warp_id_t wid,
                                               input logic [`FFLAGS_BITS-1:0] flags);
        fpu_flags_req_t f;
        f.enable = 1'b1;
        f.wid    = wid;
        f.fflags = flags;
        return f;
    endfunction

    task automatic drive(input csr_read_req_t r, input csr_write_req_t w,
                         input fpu_flags_req_t f);
        @(negedge clk);
        read_req     = r;
        write_req    = w;
        fpu_flags    = f;
        fpu_read_wid = warp_id_t'(rand32());
        cycles       = perf_ctr_t'({rand32(), rand32()});
        instret      = perf_ctr_t'({rand32(), rand32()});
    endtask

    task automatic do_read(input warp_id_t wid, input csr_addr_t addr);
        drive(rd_req(wid, rand_mask(), addr), '0, '0);
    endtask

    task automatic do_write(input warp_id_t wid, input tmask_t mask, input csr_addr_t addr);
        drive('0, wr_req(wid, mask, addr), '0);
    endtask

    task automatic end_test(input string name, input int errors_before);
        int target;
        int guard;
        drive('0, '0, '0);
        target = cycles_seen + 1;
        guard  = 0;
        while (cycles_seen < target && guard < TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (cycles_seen < target) begin
            errors++;
            $display("Timeout in test %s, the compare process stopped running", name);
        end
        if (errors == errors_before) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int        e0;
        csr_addr_t addr;
        warp_id_t  wid;
        clk          = 1'b0;
        reset        = 1'b1;
        read_req     = '0;
        write_req    = '0;
        fpu_flags    = '0;
        fpu_read_wid = '0;
        cycles       = '0;
        instret      = '0;
        rng_state    = 32'ha8dc3361;
        errors       = 0;
        checks       = 0;
        cycles_seen  = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        e0 = errors;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            for (int i = 0; i < 3; i++) begin
                do_read(warp_id_t'(w), FP_ADDR[i]);
            end
        end
        for (int i = 0; i < 9; i++) begin
            do_read(warp_id_t'(i), MACH_ADDR[i]);
        end
        end_test("reset_state", e0);

        e0 = errors;
        for (int n = 0; n < 40; n++) begin
            addr = MACH_ADDR[pick(9)];
            do_write(warp_id_t'(rand32()), rand_mask(), addr);
            do_read(warp_id_t'(rand32()), addr);
        end
        // Empty mask leaves the register alone
        for (int i = 0; i < 9; i++) begin
            do_write(warp_id_t'(i), '0, MACH_ADDR[i]);
            do_read(warp_id_t'(i), MACH_ADDR[i]);
        end
        end_test("machine_regs", e0);

        e0 = errors;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            for (int i = 0; i < 3; i++) begin
                do_write(warp_id_t'(w), rand_mask(), FP_ADDR[i]);
                for (int j = 0; j < 3; j++) begin
                    do_read(warp_id_t'(w), FP_ADDR[j]);
                end
            end
        end
        for (int n = 0; n < 24; n++) begin
            drive(rd_req(warp_id_t'(rand32()), rand_mask(), FP_ADDR[pick(3)]), '0,
                  fpu_req(warp_id_t'(rand32()), rand_flags()));
        end
        // CSR write and FPU update on the same warp in one cycle
        for (int n = 0; n < 12; n++) begin
            wid = warp_id_t'(rand32());
            drive('0, wr_req(wid, rand_mask(), FP_ADDR[pick(3)]), fpu_req(wid, '1));
            do_read(wid, `CSR_FCSR);
        end
        end_test("fp_state", e0);

        e0 = errors;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            for (int i = 0; i < 14; i++) begin
                do_read(warp_id_t'(w), ID_ADDR[i]);
            end
        end
        end_test("identity", e0);

        e0 = errors;
        for (int n = 0; n < 20; n++) begin
            do_read(warp_id_t'(rand32()), CTR_ADDR[n % 4]);
        end
        end_test("counters", e0);

        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            do_read(warp_id_t'(rand32()), BAD_ADDR[i]);
            do_write(warp_id_t'(rand32()), rand_mask(), BAD_ADDR[i]);
        end
        for (int n = 0; n < 20; n++) begin
            do_read(warp_id_t'(rand32()), csr_addr_t'(rand32()));
        end
        for (int i = 0; i < 8; i++) begin
            do_write(warp_id_t'(rand32()), rand_mask(), RO_ADDR[i]);
        end
        for (int i = 0; i < 9; i++) begin
            do_read(warp_id_t'(i), MACH_ADDR[i]);
        end
        for (int w = 0; w < `NUM_WARPS; w++) begin
            do_read(warp_id_t'(w), `CSR_FCSR);
        end
        end_test("faults", e0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_write_port.sv
verilog/csr_fcsr_bank.sv
verilog/csr_machine_regs.sv
verilog/csr_read_select.sv
verilog/csr_data.sv
dv/csr_data_checker.sv
dv/csr_data_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module csr_data_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vcsr_data_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
    exit 0
fi
exit 1

// ==== verilog/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define NUM_THREADS     4
`define NUM_WARPS       4
`define NUM_CORES       2
`define NT_BITS         $clog2(`NUM_THREADS)
`define NW_BITS         $clog2(`NUM_WARPS)

`define CSR_ADDR_BITS   12
`define FFLAGS_BITS     5
`define FRM_BITS        3
`define PERF_CTR_BITS   44

// Floating-point CSRs
`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003

`define CSR_SATP        12'h180

`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_PMPCFG0     12'h3A0
`define CSR_PMPADDR0    12'h3B0

`define CSR_MCYCLE      12'hB00
`define CSR_MINSTRET    12'hB02
`define CSR_MCYCLE_H    12'hB80
`define CSR_MINSTRET_H  12'hB82

`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13

// Thread and warp identity
`define CSR_WTID        12'hCC0
`define CSR_LTID        12'hCC1
`define CSR_GTID        12'hCC2
`define CSR_LWID        12'hCC3
`define CSR_GWID        12'hCC4
`define CSR_GCID        12'hCC5
`define CSR_TMASK       12'hCC6

`define CSR_NT          12'hFC0
`define CSR_NW          12'hFC1
`define CSR_NC          12'hFC2

`define VENDOR_ID       32'h0000_0a5c
`define ARCH_ID         32'h0000_0002
`define IMPL_ID         32'h0000_0101
// I, M and F extensions
`define MISA_STD        32'h0000_1120

`endif

// ==== verilog/csr_data.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_data
    import csr_pkg::*;
#(
    parameter int core_id = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_read_req_t        read_req,
    output thread_data_t         read_data,
    output logic                 read_fault,
    input  csr_write_req_t       write_req,
    output logic                 write_fault,
    input  fpu_flags_req_t       fpu_flags,
    input  warp_id_t             fpu_read_wid,
    output logic [`FRM_BITS-1:0] fpu_frm,
    input  perf_ctr_t            cycles,
    input  perf_ctr_t            instret
);

    csr_write_cmd_t write_cmd;
    fcsr_all_t      fcsr_all;
    mregs_t         mregs;

    csr_write_port u_write_port (
        .write_req   (write_req),
        .write_cmd   (write_cmd),
        .write_fault (write_fault)
    );

    csr_fcsr_bank u_fcsr_bank (
        .clk          (clk),
        .reset        (reset),
        .write_cmd    (write_cmd),
        .fpu_flags    (fpu_flags),
        .fpu_read_wid (fpu_read_wid),
        .fpu_frm      (fpu_frm),
        .fcsr_all     (fcsr_all)
    );

    csr_machine_regs u_machine_regs (
        .clk       (clk),
        .reset     (reset),
        .write_cmd (write_cmd),
        .mregs     (mregs)
    );

    csr_read_select #(
        .core_id (core_id)
    ) u_read_select (
        .read_req   (read_req),
        .fcsr_all   (fcsr_all),
        .mregs      (mregs),
        .cycles     (cycles),
        .instret    (instret),
        .read_data  (read_data),
        .read_fault (read_fault)
    );

endmodule

// ==== verilog/csr_fcsr_bank.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_fcsr_bank
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  csr_write_cmd_t       write_cmd,
    input  fpu_flags_req_t       fpu_flags,
    input  warp_id_t             fpu_read_wid,
    output logic [`FRM_BITS-1:0] fpu_frm,
    output fcsr_all_t            fcsr_all
);

    fcsr_all_t fcsr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr_q <= '0;
        end else begin
            // Sticky exception flags from the FPU
            if (fpu_flags.enable) begin
                fcsr_q[fpu_flags.wid].fflags <= fcsr_q[fpu_flags.wid].fflags | fpu_flags.fflags;
            end
            // Later assignment, so a CSR write beats the FPU on the same warp
            case (write_cmd.op)
                WR_FFLAGS: begin
                    fcsr_q[write_cmd.wid].fflags <= write_cmd.value[`FFLAGS_BITS-1:0];
                end
                WR_FRM: begin
                    fcsr_q[write_cmd.wid].frm <= write_cmd.value[`FRM_BITS-1:0];
                end
                WR_FCSR: begin
                    fcsr_q[write_cmd.wid] <= write_cmd.value[`FRM_BITS+`FFLAGS_BITS-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    assign fpu_frm  = fcsr_q[fpu_read_wid].frm;
    assign fcsr_all = fcsr_q;

endmodule

// ==== verilog/csr_machine_regs.sv ====
`timescale 1ns/1ps

module csr_machine_regs
    import csr_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  csr_write_cmd_t write_cmd,
    output mregs_t         mregs
);

    mregs_t mregs_q;

    // Each register loads only on its own op
    always_ff @(posedge clk) begin
        if (reset) begin
            mregs_q <= '0;
        end else begin
            case (write_cmd.op)
                WR_SATP:     mregs_q.satp     <= write_cmd.value;
                WR_MSTATUS:  mregs_q.mstatus  <= write_cmd.value;
                WR_MEDELEG:  mregs_q.medeleg  <= write_cmd.value;
                WR_MIDELEG:  mregs_q.mideleg  <= write_cmd.value;
                WR_MIE:      mregs_q.mie      <= write_cmd.value;
                WR_MTVEC:    mregs_q.mtvec    <= write_cmd.value;
                WR_MEPC:     mregs_q.mepc     <= write_cmd.value;
                WR_PMPCFG0:  mregs_q.pmpcfg0  <= write_cmd.value;
                WR_PMPADDR0: mregs_q.pmpaddr0 <= write_cmd.value;
                default: begin
                end
            endcase
        end
    end

    assign mregs = mregs_q;

endmodule

// ==== verilog/csr_pkg.sv ====
`include "csr_cfg.svh"

package csr_pkg;

    typedef logic [`NW_BITS-1:0]            warp_id_t;
    typedef logic [`NUM_THREADS-1:0]        tmask_t;
    typedef logic [`CSR_ADDR_BITS-1:0]      csr_addr_t;
    typedef logic [`NUM_THREADS-1:0][31:0]  thread_data_t;
    typedef logic [`PERF_CTR_BITS-1:0]      perf_ctr_t;

    // Same bit layout as the fcsr register
    typedef struct packed {
        logic [`FRM_BITS-1:0]    frm;
        logic [`FFLAGS_BITS-1:0] fflags;
    } fcsr_t;

    typedef fcsr_t [`NUM_WARPS-1:0] fcsr_all_t;

    typedef struct packed {
        logic      enable;
        warp_id_t  wid;
        tmask_t    tmask;
        csr_addr_t addr;
    } csr_read_req_t;

    typedef struct packed {
        logic         enable;
        warp_id_t     wid;
        tmask_t       tmask;
        csr_addr_t    addr;
        thread_data_t data;
    } csr_write_req_t;

    typedef struct packed {
        logic                    enable;
        warp_id_t                wid;
        logic [`FFLAGS_BITS-1:0] fflags;
    } fpu_flags_req_t;

    typedef enum logic [3:0] {
        WR_NONE,
        WR_FFLAGS,
        WR_FRM,
        WR_FCSR,
        WR_SATP,
        WR_MSTATUS,
        WR_MEDELEG,
        WR_MIDELEG,
        WR_MIE,
        WR_MTVEC,
        WR_MEPC,
        WR_PMPCFG0,
        WR_PMPADDR0
    } csr_write_op_e;

    typedef struct packed {
        csr_write_op_e op;
        warp_id_t      wid;
        logic [31:0]   value;
    } csr_write_cmd_t;

    typedef struct packed {
        logic [31:0] satp;
        logic [31:0] mstatus;
        logic [31:0] medeleg;
        logic [31:0] mideleg;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic [31:0] pmpcfg0;
        logic [31:0] pmpaddr0;
    } mregs_t;

endpackage

// ==== verilog/csr_read_select.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_read_select
    import csr_pkg::*;
#(
    parameter int core_id = 0
) (
    input  csr_read_req_t read_req,
    input  fcsr_all_t     fcsr_all,
    input  mregs_t        mregs,
    input  perf_ctr_t     cycles,
    input  perf_ctr_t     instret,
    output thread_data_t  read_data,
    output logic          read_fault
);

    thread_data_t wtid;
    thread_data_t ltid;
    thread_data_t gtid;
    logic [31:0]  gwid;
    fcsr_t        fcsr_sel;
    thread_data_t data_mux;
    logic         addr_valid;

    function automatic thread_data_t bcast(input logic [31:0] word);
        thread_data_t result;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            result[i] = word;
        end
        return result;
    endfunction

    assign gwid     = 32'(core_id) * `NUM_WARPS + 32'(read_req.wid);
    assign fcsr_sel = fcsr_all[read_req.wid];

    // Per-lane thread ids
    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_tid
        assign wtid[i] = 32'(i);
        assign ltid[i] = 32'(read_req.wid) * `NUM_THREADS + 32'(i);
        assign gtid[i] = gwid * `NUM_THREADS + 32'(i);
    end

    always_comb begin
        data_mux   = '0;
        addr_valid = 1'b1;
        case (read_req.addr)
            `CSR_FFLAGS:     data_mux = bcast(32'(fcsr_sel.fflags));
            `CSR_FRM:        data_mux = bcast(32'(fcsr_sel.frm));
            `CSR_FCSR:       data_mux = bcast(32'(fcsr_sel));

            `CSR_WTID:       data_mux = wtid;
            `CSR_LTID:       data_mux = ltid;
            `CSR_GTID:       data_mux = gtid;
            `CSR_LWID:       data_mux = bcast(32'(read_req.wid));
            `CSR_GWID:       data_mux = bcast(gwid);
            `CSR_GCID:       data_mux = bcast(32'(core_id));
            `CSR_TMASK:      data_mux = bcast(32'(read_req.tmask));
            `CSR_NT:         data_mux = bcast(32'(`NUM_THREADS));
            `CSR_NW:         data_mux = bcast(32'(`NUM_WARPS));
            `CSR_NC:         data_mux = bcast(32'(`NUM_CORES));

            // High halves are zero-extended
            `CSR_MCYCLE:     data_mux = bcast(cycles[31:0]);
            `CSR_MCYCLE_H:   data_mux = bcast(32'(cycles[`PERF_CTR_BITS-1:32]));
            `CSR_MINSTRET:   data_mux = bcast(instret[31:0]);
            `CSR_MINSTRET_H: data_mux = bcast(32'(instret[`PERF_CTR_BITS-1:32]));

            `CSR_SATP:       data_mux = bcast(mregs.satp);
            `CSR_MSTATUS:    data_mux = bcast(mregs.mstatus);
            `CSR_MISA:       data_mux = bcast((32'd1 << 30) | `MISA_STD);
            `CSR_MEDELEG:    data_mux = bcast(mregs.medeleg);
            `CSR_MIDELEG:    data_mux = bcast(mregs.mideleg);
            `CSR_MIE:        data_mux = bcast(mregs.mie);
            `CSR_MTVEC:      data_mux = bcast(mregs.mtvec);
            `CSR_MEPC:       data_mux = bcast(mregs.mepc);
            `CSR_PMPCFG0:    data_mux = bcast(mregs.pmpcfg0);
            `CSR_PMPADDR0:   data_mux = bcast(mregs.pmpaddr0);

            `CSR_MVENDORID:  data_mux = bcast(`VENDOR_ID);
            `CSR_MARCHID:    data_mux = bcast(`ARCH_ID);
            `CSR_MIMPID:     data_mux = bcast(`IMPL_ID);
            default:         addr_valid = 1'b0;
        endcase
    end

    assign read_data  = data_mux;
    assign read_fault = read_req.enable && !addr_valid;

endmodule

// ==== verilog/csr_write_port.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_write_port
    import csr_pkg::*;
(
    input  csr_write_req_t write_req,
    output csr_write_cmd_t write_cmd,
    output logic           write_fault
);

    csr_write_op_e op_dec;
    logic [31:0]   lane_value;

    // Scan from the top so the lowest active lane is taken last
    always_comb begin
        lane_value = '0;
        for (int i = `NUM_THREADS - 1; i >= 0; i--) begin
            if (write_req.tmask[i]) begin
                lane_value = write_req.data[i];
            end
        end
    end

    always_comb begin
        case (write_req.addr)
            `CSR_FFLAGS:   op_dec = WR_FFLAGS;
            `CSR_FRM:      op_dec = WR_FRM;
            `CSR_FCSR:     op_dec = WR_FCSR;
            `CSR_SATP:     op_dec = WR_SATP;
            `CSR_MSTATUS:  op_dec = WR_MSTATUS;
            `CSR_MEDELEG:  op_dec = WR_MEDELEG;
            `CSR_MIDELEG:  op_dec = WR_MIDELEG;
            `CSR_MIE:      op_dec = WR_MIE;
            `CSR_MTVEC:    op_dec = WR_MTVEC;
            `CSR_MEPC:     op_dec = WR_MEPC;
            `CSR_PMPCFG0:  op_dec = WR_PMPCFG0;
            `CSR_PMPADDR0: op_dec = WR_PMPADDR0;
            default:       op_dec = WR_NONE;
        endcase
    end

    // Read-only and unknown addresses both fault
    assign write_fault     = write_req.enable && (op_dec == WR_NONE);
    assign write_cmd.op    = (write_req.enable && |write_req.tmask) ? op_dec : WR_NONE;
    assign write_cmd.wid   = write_req.wid;
    assign write_cmd.value = lane_value;

endmodule
